/* rtl/idct_pkg.sv */
/*
	Shared widths, types, Wishbone address map and cosine table for the
	8x8 inverse DCT core. Modules refer to these by scoped names.
	The table holds 4096 * a(k) * cos((2n+1)k*pi/16), row n, column k.
*/
package idct_pkg;

	localparam int block_n = 64;
	localparam int dim_n = 8;

	typedef logic [5:0] addr_t;          // Row * 8 + column
	typedef logic signed [15:0] coef_t;
	typedef logic signed [12:0] cos_t;
	typedef logic signed [31:0] inter_t;
	typedef logic signed [39:0] acc_t;   // No overflow over 8 terms
	typedef logic [7:0] pixel_t;
	typedef logic [6:0] tag_t;           // Pass flag in bit 6, element below
	typedef logic [7:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// Wishbone word addresses
	localparam wb_adr_t coef_base = 8'h00;
	localparam wb_adr_t ctrl_addr = 8'h40;
	localparam wb_adr_t pixel_base = 8'h80;

	localparam int pass1_shift = 8;
	localparam int pass2_shift = 16;

	localparam cos_t cos_table [dim_n][dim_n] = '{
		'{13'sd1448, 13'sd2009, 13'sd1892, 13'sd1703,
			13'sd1448, 13'sd1138, 13'sd784, 13'sd400},
		'{13'sd1448, 13'sd1703, 13'sd784, -13'sd400,
			-13'sd1448, -13'sd2009, -13'sd1892, -13'sd1138},
		'{13'sd1448, 13'sd1138, -13'sd784, -13'sd2009,
			-13'sd1448, 13'sd400, 13'sd1892, 13'sd1703},
		'{13'sd1448, 13'sd400, -13'sd1892, -13'sd1138,
			13'sd1448, 13'sd1703, -13'sd784, -13'sd2009},
		'{13'sd1448, -13'sd400, -13'sd1892, 13'sd1138,
			13'sd1448, -13'sd1703, -13'sd784, 13'sd2009},
		'{13'sd1448, -13'sd1138, -13'sd784, 13'sd2009,
			-13'sd1448, -13'sd400, 13'sd1892, -13'sd1703},
		'{13'sd1448, -13'sd1703, 13'sd784, 13'sd400,
			-13'sd1448, 13'sd2009, -13'sd1892, 13'sd1138},
		'{13'sd1448, -13'sd2009, 13'sd1892, -13'sd1703,
			13'sd1448, -13'sd1138, 13'sd784, -13'sd400}
	};

endpackage

/* rtl/block_ram.sv */
/*
	Simple dual-port RAM of one block (64 words).
	The word type is a type parameter, so the same RAM holds coefficients,
	intermediate values or output samples. Read data is registered and
	shows up one cycle after the read address.
*/
`timescale 1ns/1ps

module block_ram #(
	parameter type word_t = idct_pkg::pixel_t
) (
	input logic CLOCK_50_I,

	input logic wr_en,
	input idct_pkg::addr_t wr_addr,
	input word_t wr_data,

	input idct_pkg::addr_t rd_addr,
	output word_t rd_data
);

word_t mem [idct_pkg::block_n];

// Old data is returned when reading the word being written
always_ff @ (posedge CLOCK_50_I) begin
	if (wr_en) begin
		mem[wr_addr] <= wr_data;
	end
	rd_data <= mem[rd_addr];
end

endmodule

/* rtl/idct_mac.sv */
/*
	Two-stage multiply-accumulate unit for the IDCT passes.
	Stage 1 registers cos * sample, stage 2 accumulates. An element runs
	from the first to the last term; its sum and tag are presented two
	cycles after the last term while the next element already accumulates.
*/
`timescale 1ns/1ps

module idct_mac (
	input logic CLOCK_50_I,
	input logic resetn,

	input logic in_valid,
	input logic first,
	input logic last,
	input idct_pkg::cos_t cos,
	input idct_pkg::inter_t sample,
	input idct_pkg::tag_t in_tag,

	output logic out_valid,
	output idct_pkg::acc_t out_sum,
	output idct_pkg::tag_t out_tag
);

logic p_valid;
logic p_first;
logic p_last;
idct_pkg::tag_t p_tag;
idct_pkg::acc_t product;
idct_pkg::acc_t acc;

always_ff @ (posedge CLOCK_50_I or negedge resetn) begin
	if (resetn == 1'b0) begin
		p_valid <= 1'b0;
		p_first <= 1'b0;
		p_last <= 1'b0;
		out_valid <= 1'b0;
	end else begin
		p_valid <= in_valid;
		p_first <= in_valid && first;
		p_last <= in_valid && last;
		out_valid <= p_valid && p_last;  // One cycle per element
	end
end

always_ff @ (posedge CLOCK_50_I) begin
	// Both operands widened first so the product keeps its sign
	product <= idct_pkg::acc_t'(cos) * idct_pkg::acc_t'(sample);
	p_tag <= in_tag;
	if (p_valid) begin
		acc <= p_first ? product : acc + product;  // Load on first term
		if (p_last) begin
			out_tag <= p_tag;
		end
	end
end

// Accumulator holds the finished sum for the out_valid cycle
assign out_sum = acc;

endmodule

/* rtl/idct_sequencer.sv */
/*
	Pass control for the 8x8 IDCT.
	Pass 1 computes T[u][m] = sum_v S[u][v] C[m][v] and stores T >>> 8.
	Pass 2 computes P[n][m] = sum_u C[n][u] T'[u][m] and writes the samples
	after >>> 16 and saturation to 0..255. One operand per cycle, eight per
	element. finish pulses once the last sample is in the pixel RAM.
*/
`timescale 1ns/1ps

module idct_sequencer (
	input logic CLOCK_50_I,
	input logic resetn,

	input logic start,
	output logic finish,

	output idct_pkg::addr_t coef_rd_addr,
	input idct_pkg::coef_t coef_rd_data,

	output logic inter_wr_en,
	output idct_pkg::addr_t inter_wr_addr,
	output idct_pkg::inter_t inter_wr_data,
	output idct_pkg::addr_t inter_rd_addr,
	input idct_pkg::inter_t inter_rd_data,

	output logic mac_valid,
	output logic mac_first,
	output logic mac_last,
	output idct_pkg::cos_t mac_cos,
	output idct_pkg::inter_t mac_sample,
	output idct_pkg::tag_t mac_tag,
	input logic mac_out_valid,
	input idct_pkg::acc_t mac_out_sum,
	input idct_pkg::tag_t mac_out_tag,

	output logic pixel_wr_en,
	output idct_pkg::addr_t pixel_wr_addr,
	output idct_pkg::pixel_t pixel_wr_data
);

typedef enum logic [2:0] {
	s_idle,
	s_pass1,
	s_drain1,  // Wait for the last T' write
	s_pass2,
	s_drain2   // Wait for the last sample write
} state_t;

state_t state;
idct_pkg::addr_t elem;  // Output element, row in [5:3], column in [2:0]
logic [2:0] term;       // Summation index
logic issue;
logic pass2;
logic last_issue;
logic last_elem_out;
idct_pkg::acc_t scaled;

assign issue = (state == s_pass1) || (state == s_pass2);
assign pass2 = (state == s_pass2);
assign last_issue = (elem == 6'd63) && (term == 3'd7);

// Operand addresses, data returns next cycle
assign coef_rd_addr = {elem[5:3], term};   // S[u][v]
assign inter_rd_addr = {term, elem[2:0]};  // T'[u][m]

always_ff @ (posedge CLOCK_50_I or negedge resetn) begin
	if (resetn == 1'b0) begin
		state <= s_idle;
		elem <= 6'd0;
		term <= 3'd0;
		mac_valid <= 1'b0;
		mac_first <= 1'b0;
		mac_last <= 1'b0;
		mac_tag <= 7'd0;
		finish <= 1'b0;
	end else begin
		// Delayed one cycle to meet the RAM read data
		mac_valid <= issue;
		mac_first <= issue && (term == 3'd0);
		mac_last <= issue && (term == 3'd7);
		mac_tag <= {pass2, elem};
		finish <= pixel_wr_en && last_elem_out;

		if (issue) begin
			term <= term + 3'd1;
			if (term == 3'd7) begin
				elem <= elem + 6'd1;  // Wraps to 0 at the end of a pass
			end
		end

		case (state)
		s_idle: begin
			if (start) state <= s_pass1;
		end
		s_pass1: begin
			if (last_issue) state <= s_drain1;
		end
		s_drain1: begin
			// Write lands at this edge, pass 2 reads from the next cycle on
			if (inter_wr_en && last_elem_out) state <= s_pass2;
		end
		s_pass2: begin
			if (last_issue) state <= s_drain2;
		end
		s_drain2: begin
			if (pixel_wr_en && last_elem_out) state <= s_idle;
		end
		default: state <= s_idle;
		endcase
	end
end

// Pass 1 uses C[m][v], pass 2 uses C[n][u]
always_ff @ (posedge CLOCK_50_I) begin
	mac_cos <= idct_pkg::cos_table[pass2 ? elem[5:3] : elem[2:0]][term];
end

assign mac_sample = mac_tag[6] ? inter_rd_data : idct_pkg::inter_t'(coef_rd_data);

// Write-back, routed by the pass flag of the tag
assign last_elem_out = (mac_out_tag[5:0] == 6'd63);

assign inter_wr_en = mac_out_valid && !mac_out_tag[6];
assign inter_wr_addr = mac_out_tag[5:0];
assign inter_wr_data = idct_pkg::inter_t'(mac_out_sum >>> idct_pkg::pass1_shift);

assign pixel_wr_en = mac_out_valid && mac_out_tag[6];
assign pixel_wr_addr = mac_out_tag[5:0];
assign scaled = mac_out_sum >>> idct_pkg::pass2_shift;

always_comb begin
	if (scaled[39]) begin
		pixel_wr_data = 8'd0;  // Negative
	end else if (scaled > idct_pkg::acc_t'(255)) begin
		pixel_wr_data = 8'd255;
	end else begin
		pixel_wr_data = scaled[7:0];
	end
end

endmodule

/* rtl/idct_regs.sv */
/*
	Wishbone classic slave of the IDCT core.
	Coefficients are written at 0x00..0x3F, control/status sits at 0x40 and
	samples are read at 0x80..0xBF. Every access is acked one cycle after
	the request. Coefficient writes and starts are dropped while busy.
*/
`timescale 1ns/1ps

module idct_regs (
	input logic CLOCK_50_I,
	input logic resetn,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input idct_pkg::wb_adr_t wb_adr,
	input idct_pkg::wb_dat_t wb_dat_w,
	output idct_pkg::wb_dat_t wb_dat_r,
	output logic wb_ack,

	output logic coef_wr_en,
	output idct_pkg::addr_t coef_wr_addr,
	output idct_pkg::coef_t coef_wr_data,

	output idct_pkg::addr_t pixel_rd_addr,
	input idct_pkg::pixel_t pixel_rd_data,

	output logic start,
	input logic finish
);

typedef enum logic [1:0] {rd_zero, rd_status, rd_pixel} rd_sel_t;

rd_sel_t rd_sel;
logic req;
logic coef_hit;
logic ctrl_hit;
logic pixel_hit;
logic start_req;
logic busy;
logic done;

assign req = wb_cyc && wb_stb && !wb_ack;  // First cycle of a transfer only

assign coef_hit = (wb_adr[7:6] == idct_pkg::coef_base[7:6]);
assign ctrl_hit = (wb_adr == idct_pkg::ctrl_addr);
assign pixel_hit = (wb_adr[7:6] == idct_pkg::pixel_base[7:6]);

assign coef_wr_en = req && wb_we && coef_hit && !busy;
assign coef_wr_addr = wb_adr[5:0];
assign coef_wr_data = wb_dat_w[15:0];
assign start_req = req && wb_we && ctrl_hit && wb_dat_w[0] && !busy;

// Address held by the master, so RAM data is ready with ack
assign pixel_rd_addr = wb_adr[5:0];

always_ff @ (posedge CLOCK_50_I or negedge resetn) begin
	if (resetn == 1'b0) begin
		wb_ack <= 1'b0;
		start <= 1'b0;
		busy <= 1'b0;
		done <= 1'b0;
		rd_sel <= rd_zero;
	end else begin
		wb_ack <= req;
		start <= start_req;

		if (start_req) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (finish) begin
			busy <= 1'b0;
			done <= 1'b1;
		end

		if (req) begin
			if (ctrl_hit) rd_sel <= rd_status;
			else if (pixel_hit) rd_sel <= rd_pixel;
			else rd_sel <= rd_zero;
		end
	end
end

always_comb begin
	case (rd_sel)
	rd_status: wb_dat_r = {30'd0, done, busy};
	rd_pixel: wb_dat_r = {24'd0, pixel_rd_data};  // Zero-extended sample
	default: wb_dat_r = 32'd0;
	endcase
end

endmodule

/* rtl/idct_top.sv */
/*
	Top level of the 8x8 IDCT core with a Wishbone classic slave port.
	The host loads 64 coefficients, starts the transform, polls done and
	reads back 64 samples. Holds the register block, the sequencer, one
	multiply-accumulate unit and the coefficient, intermediate and pixel RAMs.
*/
`timescale 1ns/1ps

module idct_top (
	input logic CLOCK_50_I,
	input logic resetn,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input idct_pkg::wb_adr_t wb_adr,
	input idct_pkg::wb_dat_t wb_dat_w,
	output idct_pkg::wb_dat_t wb_dat_r,
	output logic wb_ack
);

logic start, finish;

logic coef_wr_en;
idct_pkg::addr_t coef_wr_addr, coef_rd_addr;
idct_pkg::coef_t coef_wr_data, coef_rd_data;

logic inter_wr_en;
idct_pkg::addr_t inter_wr_addr, inter_rd_addr;
idct_pkg::inter_t inter_wr_data, inter_rd_data;

logic pixel_wr_en;
idct_pkg::addr_t pixel_wr_addr, pixel_rd_addr;
idct_pkg::pixel_t pixel_wr_data, pixel_rd_data;

logic mac_valid, mac_first, mac_last, mac_out_valid;
idct_pkg::cos_t mac_cos;
idct_pkg::inter_t mac_sample;
idct_pkg::tag_t mac_tag, mac_out_tag;
idct_pkg::acc_t mac_out_sum;

idct_regs regs_unit (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_dat_w(wb_dat_w),
	.wb_dat_r(wb_dat_r),
	.wb_ack(wb_ack),
	.coef_wr_en(coef_wr_en),
	.coef_wr_addr(coef_wr_addr),
	.coef_wr_data(coef_wr_data),
	.pixel_rd_addr(pixel_rd_addr),
	.pixel_rd_data(pixel_rd_data),
	.start(start),
	.finish(finish)
);

idct_sequencer seq_unit (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.start(start),
	.finish(finish),
	.coef_rd_addr(coef_rd_addr),
	.coef_rd_data(coef_rd_data),
	.inter_wr_en(inter_wr_en),
	.inter_wr_addr(inter_wr_addr),
	.inter_wr_data(inter_wr_data),
	.inter_rd_addr(inter_rd_addr),
	.inter_rd_data(inter_rd_data),
	.mac_valid(mac_valid),
	.mac_first(mac_first),
	.mac_last(mac_last),
	.mac_cos(mac_cos),
	.mac_sample(mac_sample),
	.mac_tag(mac_tag),
	.mac_out_valid(mac_out_valid),
	.mac_out_sum(mac_out_sum),
	.mac_out_tag(mac_out_tag),
	.pixel_wr_en(pixel_wr_en),
	.pixel_wr_addr(pixel_wr_addr),
	.pixel_wr_data(pixel_wr_data)
);

idct_mac mac_unit (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.in_valid(mac_valid),
	.first(mac_first),
	.last(mac_last),
	.cos(mac_cos),
	.sample(mac_sample),
	.in_tag(mac_tag),
	.out_valid(mac_out_valid),
	.out_sum(mac_out_sum),
	.out_tag(mac_out_tag)
);

// Input coefficients S
block_ram #(.word_t(idct_pkg::coef_t)) coef_ram (
	.CLOCK_50_I(CLOCK_50_I),
	.wr_en(coef_wr_en),
	.wr_addr(coef_wr_addr),
	.wr_data(coef_wr_data),
	.rd_addr(coef_rd_addr),
	.rd_data(coef_rd_data)
);

// Scaled pass 1 results T'
block_ram #(.word_t(idct_pkg::inter_t)) inter_ram (
	.CLOCK_50_I(CLOCK_50_I),
	.wr_en(inter_wr_en),
	.wr_addr(inter_wr_addr),
	.wr_data(inter_wr_data),
	.rd_addr(inter_rd_addr),
	.rd_data(inter_rd_data)
);

block_ram #(.word_t(idct_pkg::pixel_t)) pixel_ram (
	.CLOCK_50_I(CLOCK_50_I),
	.wr_en(pixel_wr_en),
	.wr_addr(pixel_wr_addr),
	.wr_data(pixel_wr_data),
	.rd_addr(pixel_rd_addr),
	.rd_data(pixel_rd_data)
);

endmodule

/* bench/idct_bench_tasks.svh */
/*
	Wishbone classic master tasks and the reference model of the 8x8 IDCT.
	Included inside the testbench module. The tasks drive its bus signals
	and update its check and error counters directly.
*/
`ifndef IDCT_BENCH_TASKS_SVH
`define IDCT_BENCH_TASKS_SVH

localparam int ack_limit = 16;  // Cycles before a missing ack is reported

// One classic cycle with the request held until ack
task automatic run_bus_cycle(input logic we, input idct_pkg::wb_adr_t adr,
		input idct_pkg::wb_dat_t wdata, output idct_pkg::wb_dat_t rdata);
	int waited;
	logic acked;
	rdata = '0;
	acked = 1'b0;
	waited = 0;
	@(negedge CLOCK_50_I);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = we;
	wb_adr = adr;
	wb_dat_w = wdata;
	while (!acked && waited < ack_limit) begin
		@(negedge CLOCK_50_I);
		waited++;
		if (wb_ack) begin
			acked = 1'b1;
			rdata = wb_dat_r;  // Valid while ack is high
		end
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
	if (!acked) begin
		$display("No ack came within %0d cycles for address 0x%02h", ack_limit, adr);
		protocol_errors++;
	end else begin
		if (waited != 1) begin
			$display("Ack for address 0x%02h came after %0d cycles instead of one",
				adr, waited);
			protocol_errors++;
		end
		@(negedge CLOCK_50_I);
		if (wb_ack) begin
			$display("Ack for address 0x%02h stayed high for more than one cycle", adr);
			protocol_errors++;
		end
	end
endtask

task automatic wb_write(input idct_pkg::wb_adr_t adr, input idct_pkg::wb_dat_t data);
	idct_pkg::wb_dat_t ignored;
	run_bus_cycle(1'b1, adr, data, ignored);
endtask

task automatic wb_read(input idct_pkg::wb_adr_t adr, output idct_pkg::wb_dat_t data);
	run_bus_cycle(1'b0, adr, 32'h0, data);
endtask

task automatic check_value(input string what, input idct_pkg::wb_dat_t actual,
		input idct_pkg::wb_dat_t want);
	checks++;
	if (actual !== want) begin
		$display("error %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, want);
		value_errors++;
	end
endtask

// Row pass then column pass in 64-bit integers
function automatic void idct_model(input idct_pkg::coef_t s [idct_pkg::block_n],
		output idct_pkg::pixel_t p [idct_pkg::block_n]);
	longint t [idct_pkg::block_n];
	longint sum;
	int u;
	int v;
	int m;
	int n;
	for (u = 0; u < 8; u++) begin
		for (m = 0; m < 8; m++) begin
			sum = 64'sd0;
			for (v = 0; v < 8; v++) begin
				sum += longint'(s[u * 8 + v]) * longint'(idct_pkg::cos_table[m][v]);
			end
			t[u * 8 + m] = sum >>> idct_pkg::pass1_shift;
		end
	end
	for (n = 0; n < 8; n++) begin
		for (m = 0; m < 8; m++) begin
			sum = 64'sd0;
			for (u = 0; u < 8; u++) begin
				sum += longint'(idct_pkg::cos_table[n][u]) * t[u * 8 + m];
			end
			sum = sum >>> idct_pkg::pass2_shift;
			if (sum < 64'sd0) p[n * 8 + m] = 8'd0;
			else if (sum > 64'sd255) p[n * 8 + m] = 8'd255;
			else p[n * 8 + m] = idct_pkg::pixel_t'(sum);
		end
	end
endfunction

`endif

/* bench/idct_tb.sv */
/*
	Testbench of the IDCT core. A Wishbone master loads seeded random and
	corner-case blocks, starts each transform, polls done and compares all
	64 samples with the reference model. Also covers the address map, busy
	protection and restart. Errors are counted and summed up at the end.
*/
`timescale 1ns/1ps

module idct_tb;

localparam int clock_period = 20;
localparam int block_budget = 24;
localparam int cycles_per_block = 3000;  // Load, transform, read back
localparam int poll_limit = 1000;

logic CLOCK_50_I;
logic resetn;
logic wb_cyc;
logic wb_stb;
logic wb_we;
idct_pkg::wb_adr_t wb_adr;
idct_pkg::wb_dat_t wb_dat_w;
idct_pkg::wb_dat_t wb_dat_r;
logic wb_ack;

idct_pkg::coef_t coefs [idct_pkg::block_n];
idct_pkg::pixel_t expected [idct_pkg::block_n];
int checks;
int value_errors;
int protocol_errors;

`include "idct_bench_tasks.svh"

idct_top DUT (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_dat_w(wb_dat_w),
	.wb_dat_r(wb_dat_r),
	.wb_ack(wb_ack)
);

initial begin
	CLOCK_50_I = 1'b0;
	forever #(clock_period / 2) CLOCK_50_I = ~CLOCK_50_I;
end

task automatic load_block();
	int i;
	for (i = 0; i < idct_pkg::block_n; i++) begin
		wb_write(idct_pkg::coef_base + idct_pkg::wb_adr_t'(i), {16'd0, coefs[i]});
	end
endtask

task automatic wait_done();
	idct_pkg::wb_dat_t status;
	int polls;
	status = '0;
	polls = 0;
	while (status[1] == 1'b0 && polls < poll_limit) begin
		wb_read(idct_pkg::ctrl_addr, status);
		polls++;
	end
	if (status[1] == 1'b0) begin
		$display("The transform never finished, done stayed low for %0d status reads", polls);
		protocol_errors++;
	end else begin
		check_value("status at done", status, 32'h2);  // Done set and busy clear
	end
endtask

task automatic check_samples(input string label);
	idct_pkg::wb_dat_t data;
	int i;
	for (i = 0; i < idct_pkg::block_n; i++) begin
		wb_read(idct_pkg::pixel_base + idct_pkg::wb_adr_t'(i), data);
		check_value($sformatf("%s sample %0d", label, i), data, {24'd0, expected[i]});
	end
endtask

task automatic run_block(input string label);
	load_block();
	idct_model(coefs, expected);
	wb_write(idct_pkg::ctrl_addr, 32'h1);
	wait_done();
	check_samples(label);
endtask

// Fixed sample value over the whole block for the saturation corners
task automatic check_uniform(input string label, input idct_pkg::pixel_t value);
	idct_pkg::wb_dat_t data;
	int i;
	for (i = 0; i < idct_pkg::block_n; i++) begin
		wb_read(idct_pkg::pixel_base + idct_pkg::wb_adr_t'(i), data);
		check_value($sformatf("%s uniform sample %0d", label, i), data, {24'd0, value});
	end
endtask

initial begin
	#(block_budget * cycles_per_block * clock_period);
	$display("Watchdog expired, the run took longer than %0d blocks allow", block_budget);
	$display("checks %0d, value errors %0d, protocol errors %0d", checks, value_errors,
		protocol_errors);
	$display("Test failed");
	$finish;
end

initial begin
	idct_pkg::wb_dat_t data;
	int blk;
	int i;
	checks = 0;
	value_errors = 0;
	protocol_errors = 0;
	resetn = 1'b0;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
	wb_adr = '0;
	wb_dat_w = '0;
	void'($urandom(32'haa34a259));
	repeat (5) @(posedge CLOCK_50_I);
	@(negedge CLOCK_50_I);
	resetn = 1'b1;

	// Status and address map after reset
	wb_read(idct_pkg::ctrl_addr, data);
	check_value("status after reset", data, 32'h0);
	wb_write(idct_pkg::ctrl_addr, 32'hffff_fffe);  // Start bit clear
	wb_write(8'h41, 32'h1);
	wb_read(idct_pkg::ctrl_addr, data);
	check_value("status after writes without start", data, 32'h0);
	wb_read(8'h41, data);
	check_value("unmapped read 0x41", data, 32'h0);
	wb_read(8'hc0, data);
	check_value("unmapped read 0xc0", data, 32'h0);
	wb_read(idct_pkg::coef_base + 8'd5, data);
	check_value("coefficient address read", data, 32'h0);

	for (blk = 0; blk < 20; blk++) begin
		for (i = 0; i < idct_pkg::block_n; i++) coefs[i] = idct_pkg::coef_t'($urandom);
		run_block($sformatf("random block %0d", blk));
	end

	// Zero block and DC saturation both ways
	for (i = 0; i < idct_pkg::block_n; i++) coefs[i] = '0;
	run_block("zero block");
	check_uniform("zero block", 8'd0);
	coefs[0] = 16'sh7fff;
	run_block("dc max");
	check_uniform("dc max", 8'd255);
	coefs[0] = 16'sh8000;
	run_block("dc min");
	check_uniform("dc min", 8'd0);

	// Writes and a second start while busy must be dropped
	for (i = 0; i < idct_pkg::block_n; i++) coefs[i] = idct_pkg::coef_t'($urandom);
	load_block();
	idct_model(coefs, expected);
	wb_write(idct_pkg::ctrl_addr, 32'h1);
	wb_read(idct_pkg::ctrl_addr, data);
	check_value("status right after start", data, 32'h1);
	for (i = 0; i < 16; i++) begin
		wb_write(idct_pkg::coef_base + idct_pkg::wb_adr_t'($urandom_range(63)), $urandom);
	end
	wb_write(idct_pkg::ctrl_addr, 32'h1);
	wait_done();
	check_samples("busy protected block");

	// Restart on the same coefficients with done cleared meanwhile
	wb_write(idct_pkg::ctrl_addr, 32'h1);
	wb_read(idct_pkg::ctrl_addr, data);
	check_value("status right after restart", data, 32'h1);
	wait_done();
	check_samples("restarted block");

	$display("checks %0d, value errors %0d, protocol errors %0d", checks, value_errors,
		protocol_errors);
	if (value_errors == 0 && protocol_errors == 0) begin
		$display("Test completed successfully");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

/* all.f */
+incdir+bench
rtl/idct_pkg.sv
rtl/block_ram.sv
rtl/idct_mac.sv
rtl/idct_sequencer.sv
rtl/idct_regs.sv
rtl/idct_top.sv
bench/idct_tb.sv

/* run.sh */
#!/bin/sh
# Builds the IDCT testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module idct_tb -o idct_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/idct_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
